// File: logic/cache_pkg.sv
package cache_pkg;

    // Word address width and word index width inside a 4-word line
    localparam int ADDR_WORD_BITS = 23;
    localparam int LINE_WORD_SEL_BITS = 2;

    typedef logic [24:0]  byte_addr_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_data_t;
    typedef logic [20:0]  mem_addr_t;
    typedef logic [LINE_WORD_SEL_BITS-1:0] word_sel_t;

    // Source of the row written into a way
    typedef logic [1:0] wb_src_t;
    localparam wb_src_t WB_MERGE = 2'd0;
    localparam wb_src_t WB_FILL  = 2'd1;
    localparam wb_src_t WB_INVAL = 2'd2;
    localparam wb_src_t WB_SWEEP = 2'd3;

    typedef enum logic [2:0] {
        st_sweep,
        st_idle,
        st_check,
        st_fill,
        st_flush,
        st_flush_wait,
        st_write_apply,
        st_reply
    } ctrl_state_t;

endpackage

// File: logic/cache_way_ram.sv
`timescale 1ns/1ps

module cache_way_ram #(
    parameter int set_bits = 8,
    localparam int tag_bits =
        cache_pkg::ADDR_WORD_BITS - set_bits - cache_pkg::LINE_WORD_SEL_BITS
) (
    input  logic                  clk,
    input  logic [set_bits-1:0]   index,
    input  logic                  we,
    input  logic                  wr_lru,
    input  logic                  wr_valid,
    input  logic                  wr_dirty,
    input  logic [tag_bits-1:0]   wr_tag,
    input  cache_pkg::line_data_t wr_data,
    output logic                  rd_lru,
    output logic                  rd_valid,
    output logic                  rd_dirty,
    output logic [tag_bits-1:0]   rd_tag,
    output cache_pkg::line_data_t rd_data
);
    import cache_pkg::*;

    // Row holds lru, valid, dirty, tag and line from the top down
    localparam int row_bits = 3 + tag_bits + $bits(line_data_t);

    logic [row_bits-1:0] rows [2**set_bits];
    logic [row_bits-1:0] wr_row;
    logic [row_bits-1:0] rd_row;

    assign wr_row = {wr_lru, wr_valid, wr_dirty, wr_tag, wr_data};

    // A written row shows up on the read port in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            rows[index] <= wr_row;
            rd_row      <= wr_row;
        end else begin
            rd_row <= rows[index];
        end
    end

    assign {rd_lru, rd_valid, rd_dirty, rd_tag, rd_data} = rd_row;

endmodule

// File: logic/hit_check.sv
`timescale 1ns/1ps

module hit_check #(
    parameter int set_bits = 8,
    localparam int tag_bits =
        cache_pkg::ADDR_WORD_BITS - set_bits - cache_pkg::LINE_WORD_SEL_BITS
) (
    input  cache_pkg::byte_addr_t sys_addr,
    input  cache_pkg::line_data_t mem_rdata,
    input  logic                  rd_valid_0,
    input  logic                  rd_valid_1,
    input  logic [tag_bits-1:0]   rd_tag_0,
    input  logic [tag_bits-1:0]   rd_tag_1,
    input  logic                  rd_lru_0,
    input  logic                  rd_lru_1,
    input  logic                  rd_dirty_0,
    input  logic                  rd_dirty_1,
    input  cache_pkg::line_data_t rd_data_0,
    input  cache_pkg::line_data_t rd_data_1,
    output logic                  hit_0,
    output logic                  hit_1,
    output cache_pkg::word_t      hit_word,
    output cache_pkg::word_t      fill_word,
    output logic                  victim_way,
    output logic                  victim_dirty,
    output logic [tag_bits-1:0]   victim_tag
);
    import cache_pkg::*;

    logic [tag_bits-1:0] req_tag;
    word_sel_t           word_sel;

    function automatic word_t pick_word(line_data_t line, word_sel_t sel);
        return line[sel*32 +: 32];
    endfunction

    assign req_tag  = sys_addr[24:set_bits+4];
    assign word_sel = sys_addr[3:2];

    // Compare straight off the RAM read port
    assign hit_0 = rd_valid_0 && (rd_tag_0 == req_tag);
    assign hit_1 = rd_valid_1 && (rd_tag_1 == req_tag);

    assign hit_word  = pick_word(hit_0 ? rd_data_0 : rd_data_1, word_sel);
    assign fill_word = pick_word(mem_rdata, word_sel);

    // Differing LRU bits mark way 1 as newer and make way 0 the victim
    assign victim_way = (rd_lru_0 == rd_lru_1);

    // Only a valid dirty line needs writing back
    assign victim_dirty = victim_way ? (rd_valid_1 && rd_dirty_1)
                                     : (rd_valid_0 && rd_dirty_0);
    assign victim_tag   = victim_way ? rd_tag_1 : rd_tag_0;

endmodule

// File: logic/line_merge.sv
`timescale 1ns/1ps

module line_merge #(
    parameter int set_bits = 8,
    localparam int tag_bits =
        cache_pkg::ADDR_WORD_BITS - set_bits - cache_pkg::LINE_WORD_SEL_BITS
) (
    input  logic                  clk,
    input  cache_pkg::byte_addr_t sys_addr,
    input  cache_pkg::word_t      sys_wdata,
    input  cache_pkg::strb_t      sys_wstrb,
    input  cache_pkg::line_data_t mem_rdata,
    input  cache_pkg::wb_src_t    wb_src,
    input  logic                  victim_way,
    input  logic                  rd_lru_0, rd_dirty_0,
    input  logic                  rd_lru_1, rd_dirty_1,
    input  logic [tag_bits-1:0]   rd_tag_0, rd_tag_1,
    input  cache_pkg::line_data_t rd_data_0, rd_data_1,
    output logic                  wr_lru_0, wr_valid_0, wr_dirty_0,
    output logic                  wr_lru_1, wr_valid_1, wr_dirty_1,
    output logic [tag_bits-1:0]   wr_tag_0, wr_tag_1,
    output cache_pkg::line_data_t wr_data_0, wr_data_1,
    output cache_pkg::line_data_t mem_wdata
);
    import cache_pkg::*;

    logic [tag_bits-1:0] req_tag;
    word_sel_t           word_sel;
    logic                write_access;

    // Overlay the strobed bytes of the system word onto the addressed word
    function automatic line_data_t merge_bytes(line_data_t line, word_sel_t sel,
                                               word_t wdata, strb_t strb);
        line_data_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                merged[sel*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign req_tag      = sys_addr[24:set_bits+4];
    assign word_sel     = sys_addr[3:2];
    assign write_access = (sys_wstrb != '0);

    always_comb begin
        // Way 0 copies way 1 and way 1 inverts way 0 to become newest
        wr_lru_0   = rd_lru_1;
        wr_lru_1   = !rd_lru_0;
        wr_valid_0 = 1'b0;
        wr_valid_1 = 1'b0;
        wr_dirty_0 = 1'b0;
        wr_dirty_1 = 1'b0;
        wr_tag_0   = '0;
        wr_tag_1   = '0;
        wr_data_0  = '0;
        wr_data_1  = '0;
        case (wb_src)
            WB_MERGE: begin
                wr_valid_0 = 1'b1;
                wr_valid_1 = 1'b1;
                wr_dirty_0 = write_access || rd_dirty_0;
                wr_dirty_1 = write_access || rd_dirty_1;
                wr_tag_0   = rd_tag_0;
                wr_tag_1   = rd_tag_1;
                wr_data_0  = merge_bytes(rd_data_0, word_sel, sys_wdata, sys_wstrb);
                wr_data_1  = merge_bytes(rd_data_1, word_sel, sys_wdata, sys_wstrb);
            end
            WB_FILL: begin
                wr_valid_0 = 1'b1;
                wr_valid_1 = 1'b1;
                wr_tag_0   = req_tag;
                wr_tag_1   = req_tag;
                wr_data_0  = mem_rdata;
                wr_data_1  = mem_rdata;
            end
            WB_INVAL: begin
                // An invalidated way turns oldest so the recheck refills it
                wr_lru_0 = !rd_lru_1;
                wr_lru_1 = rd_lru_0;
            end
            default: begin
                // Sweep rows start with known LRU bits
                wr_lru_0 = 1'b0;
                wr_lru_1 = 1'b0;
            end
        endcase
    end

    // Victim line captured during the lookup that starts a flush
    always_ff @(posedge clk) begin
        mem_wdata <= victim_way ? rd_data_1 : rd_data_0;
    end

endmodule

// File: logic/init_sweep_counter.sv
`timescale 1ns/1ps

module init_sweep_counter #(
    parameter int set_bits = 8
) (
    input  logic                clk,
    input  logic                rst,
    output logic [set_bits-1:0] sweep_index,
    output logic                sweep_done
);

    logic running;

    // Top index is held one extra cycle while the write enables come up
    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_index <= '1;
            running     <= 1'b0;
            sweep_done  <= 1'b0;
        end else if (!sweep_done) begin
            running <= 1'b1;
            if (running) begin
                if (sweep_index == '0) begin
                    sweep_done <= 1'b1;
                end else begin
                    sweep_index <= sweep_index - 1'b1;
                end
            end
        end
    end

    // Once cleared the tags stay trusted until the next reset
    assert property (@(posedge clk) disable iff (rst) sweep_done |=> sweep_done)
        else $error("sweep_done fell after the sweep finished");

endmodule

// File: logic/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               sys_valid,
    input  cache_pkg::strb_t   sys_wstrb,
    input  logic               sweep_done,
    input  logic               hit_0,
    input  logic               hit_1,
    input  cache_pkg::word_t   hit_word,
    input  cache_pkg::word_t   fill_word,
    input  logic               victim_way,
    input  logic               victim_dirty,
    input  logic               mem_ready,
    output logic               sys_ready,
    output cache_pkg::word_t   sys_rdata,
    output logic               mem_valid,
    output logic               mem_write,
    output logic               mem_addr_sel,
    output logic               way_we_0,
    output logic               way_we_1,
    output cache_pkg::wb_src_t wb_src,
    output logic               addr_sel
);
    import cache_pkg::*;

    ctrl_state_t state;

    // A flush targets the victim line and a fill the request line
    assign mem_addr_sel = mem_write;
    assign addr_sel     = (state == st_sweep);

    ////////////////////////////////////////////////////////////////////
    // Request sequencing
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_sweep;
            sys_ready <= 1'b0;
            mem_valid <= 1'b0;
            mem_write <= 1'b0;
            way_we_0  <= 1'b0;
            way_we_1  <= 1'b0;
            wb_src    <= WB_SWEEP;
        end else begin
            case (state)
                st_sweep: begin
                    way_we_0 <= !sweep_done;
                    way_we_1 <= !sweep_done;
                    if (sweep_done) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (sys_valid) begin
                        state <= st_check;
                    end
                end
                st_check: begin
                    if (hit_0 || hit_1) begin
                        // Row is rewritten for LRU and any write bytes
                        sys_rdata <= hit_word;
                        way_we_0  <= hit_0;
                        way_we_1  <= !hit_0;
                        wb_src    <= WB_MERGE;
                        state     <= st_write_apply;
                    end else begin
                        mem_valid <= 1'b1;
                        mem_write <= victim_dirty;
                        state     <= victim_dirty ? st_flush : st_fill;
                    end
                end
                st_fill: begin
                    if (mem_ready) begin
                        way_we_0 <= !victim_way;
                        way_we_1 <= victim_way;
                        wb_src   <= WB_FILL;
                        state    <= st_write_apply;
                    end
                end
                st_flush: begin
                    if (mem_ready) begin
                        mem_valid <= 1'b0;
                        way_we_0  <= !victim_way;
                        way_we_1  <= victim_way;
                        wb_src    <= WB_INVAL;
                        state     <= st_flush_wait;
                    end
                end
                st_flush_wait: begin
                    way_we_0 <= 1'b0;
                    way_we_1 <= 1'b0;
                    if (!mem_ready) begin
                        state <= st_check;
                    end
                end
                st_write_apply: begin
                    // Fill data stays on mem_rdata until mem_valid drops here
                    way_we_0  <= 1'b0;
                    way_we_1  <= 1'b0;
                    mem_valid <= 1'b0;
                    if (wb_src == WB_FILL && sys_wstrb != '0) begin
                        // The filled line hits on the recheck and takes the write
                        state <= st_check;
                    end else begin
                        if (wb_src == WB_FILL) begin
                            sys_rdata <= fill_word;
                        end
                        sys_ready <= 1'b1;
                        state     <= st_reply;
                    end
                end
                st_reply: begin
                    if (!sys_valid) begin
                        sys_ready <= 1'b0;
                        state     <= st_idle;
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////

    // No reply may overlap an outstanding write-back
    assert property (@(posedge clk) disable iff (rst)
        (state == st_flush) |-> !(mem_valid && sys_ready))
        else $error("sys_ready high while a flush is outstanding");

    // Only the sweep writes both ways at once
    assert property (@(posedge clk) disable iff (rst)
        (state != st_sweep) |-> !(way_we_0 && way_we_1))
        else $error("both way write enables high outside the sweep");

endmodule

// File: logic/ddr_cache.sv
`timescale 1ns/1ps

module ddr_cache #(
    parameter int set_bits = 8,
    localparam int tag_bits =
        cache_pkg::ADDR_WORD_BITS - set_bits - cache_pkg::LINE_WORD_SEL_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::byte_addr_t sys_addr,
    input  cache_pkg::word_t      sys_wdata,
    output cache_pkg::word_t      sys_rdata,
    input  cache_pkg::strb_t      sys_wstrb,
    input  logic                  sys_valid,
    output logic                  sys_ready,
    output cache_pkg::mem_addr_t  mem_addr,
    output cache_pkg::line_data_t mem_wdata,
    input  cache_pkg::line_data_t mem_rdata,
    output logic                  mem_write,
    output logic                  mem_valid,
    input  logic                  mem_ready
);
    import cache_pkg::*;

    logic [set_bits-1:0] sweep_index;
    logic [set_bits-1:0] ram_index;
    logic                sweep_done;
    logic                addr_sel;
    logic                mem_addr_sel;
    wb_src_t             wb_src;

    logic                way_we_0, way_we_1;
    logic                rd_lru_0, rd_valid_0, rd_dirty_0;
    logic                rd_lru_1, rd_valid_1, rd_dirty_1;
    logic [tag_bits-1:0] rd_tag_0, rd_tag_1;
    line_data_t          rd_data_0, rd_data_1;
    logic                wr_lru_0, wr_valid_0, wr_dirty_0;
    logic                wr_lru_1, wr_valid_1, wr_dirty_1;
    logic [tag_bits-1:0] wr_tag_0, wr_tag_1;
    line_data_t          wr_data_0, wr_data_1;

    logic                hit_0, hit_1;
    word_t               hit_word, fill_word;
    logic                victim_way, victim_dirty;
    logic [tag_bits-1:0] victim_tag;

    // Set index follows the sweep until every row is cleared
    assign ram_index = addr_sel ? sweep_index : sys_addr[set_bits+3:4];

    // Victim line goes back to its own address, a fill fetches the request line
    assign mem_addr = mem_addr_sel ? {victim_tag, sys_addr[set_bits+3:4]} : sys_addr[24:4];

    ////////////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////////////

    init_sweep_counter #(.set_bits(set_bits)) u_sweep (
        .clk, .rst, .sweep_index, .sweep_done
    );

    cache_way_ram #(.set_bits(set_bits)) u_way_0 (
        .clk,
        .index  (ram_index),   .we      (way_we_0),
        .wr_lru (wr_lru_0),    .wr_valid(wr_valid_0), .wr_dirty(wr_dirty_0),
        .wr_tag (wr_tag_0),    .wr_data (wr_data_0),
        .rd_lru (rd_lru_0),    .rd_valid(rd_valid_0), .rd_dirty(rd_dirty_0),
        .rd_tag (rd_tag_0),    .rd_data (rd_data_0)
    );

    cache_way_ram #(.set_bits(set_bits)) u_way_1 (
        .clk,
        .index  (ram_index),   .we      (way_we_1),
        .wr_lru (wr_lru_1),    .wr_valid(wr_valid_1), .wr_dirty(wr_dirty_1),
        .wr_tag (wr_tag_1),    .wr_data (wr_data_1),
        .rd_lru (rd_lru_1),    .rd_valid(rd_valid_1), .rd_dirty(rd_dirty_1),
        .rd_tag (rd_tag_1),    .rd_data (rd_data_1)
    );

    ////////////////////////////////////////////////////////////////////
    // Lookup, merge and control
    ////////////////////////////////////////////////////////////////////

    hit_check #(.set_bits(set_bits)) u_hit (
        .sys_addr, .mem_rdata,
        .rd_valid_0, .rd_valid_1, .rd_tag_0, .rd_tag_1,
        .rd_lru_0, .rd_lru_1, .rd_dirty_0, .rd_dirty_1,
        .rd_data_0, .rd_data_1,
        .hit_0, .hit_1, .hit_word, .fill_word,
        .victim_way, .victim_dirty, .victim_tag
    );

    line_merge #(.set_bits(set_bits)) u_merge (
        .clk, .sys_addr, .sys_wdata, .sys_wstrb, .mem_rdata, .wb_src, .victim_way,
        .rd_lru_0, .rd_dirty_0, .rd_lru_1, .rd_dirty_1,
        .rd_tag_0, .rd_tag_1, .rd_data_0, .rd_data_1,
        .wr_lru_0, .wr_valid_0, .wr_dirty_0, .wr_lru_1, .wr_valid_1, .wr_dirty_1,
        .wr_tag_0, .wr_tag_1, .wr_data_0, .wr_data_1,
        .mem_wdata
    );

    cache_ctrl u_ctrl (
        .clk, .rst, .sys_valid, .sys_wstrb, .sweep_done,
        .hit_0, .hit_1, .hit_word, .fill_word, .victim_way, .victim_dirty,
        .mem_ready, .sys_ready, .sys_rdata, .mem_valid, .mem_write, .mem_addr_sel,
        .way_we_0, .way_we_1, .wb_src, .addr_sel
    );

endmodule

// File: verif/ddr_mem_model.sv
`timescale 1ns/1ps

module ddr_mem_model #(
    parameter int latency     = 3,
    parameter int line_bits   = 10,
    parameter int log_depth   = 1024,
    parameter int drive_delay = 2
) (
    input  logic                  clk,
    input  logic                  rst,
    input  cache_pkg::mem_addr_t  mem_addr,
    input  cache_pkg::line_data_t mem_wdata,
    input  logic                  mem_write,
    input  logic                  mem_valid,
    output cache_pkg::line_data_t mem_rdata,
    output logic                  mem_ready
);
    import cache_pkg::*;

    line_data_t lines   [2**line_bits];
    logic       written [2**line_bits];

    // Every line written by the cache, in arrival order
    mem_addr_t  log_addr [log_depth];
    line_data_t log_data [log_depth];
    int         log_count  = 0;
    int         fill_count = 0;
    int         wait_cnt   = 0;

    // Untouched word w holds w XOR 5A5A0000
    function automatic line_data_t initial_line(mem_addr_t line);
        line_data_t data;
        word_sel_t  sel;
        for (int w = 0; w < 4; w++) begin
            sel = word_sel_t'(w);
            data[w*32 +: 32] = {9'd0, line, sel} ^ 32'h5A5A0000;
        end
        return data;
    endfunction

    task automatic serve_request();
        int idx;
        idx = int'(mem_addr[line_bits-1:0]);
        if (mem_write) begin
            lines[idx]   = mem_wdata;
            written[idx] = 1'b1;
            if (log_count < log_depth) begin
                log_addr[log_count] = mem_addr;
                log_data[log_count] = mem_wdata;
            end
            log_count++;
        end else begin
            mem_rdata = written[idx] ? lines[idx] : initial_line(mem_addr);
            fill_count++;
        end
    endtask

    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        for (int i = 0; i < 2**line_bits; i++) begin
            written[i] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Request handling, sampled just after each rising edge
    ////////////////////////////////////////////////////////////////////

    always begin
        @(posedge clk);
        #(drive_delay);
        if (rst) begin
            mem_ready = 1'b0;
            wait_cnt  = 0;
        end else if (mem_ready) begin
            // Reply stays up until the cache takes its request away
            if (!mem_valid) begin
                mem_ready = 1'b0;
            end
        end else if (mem_valid) begin
            wait_cnt++;
            if (wait_cnt == latency) begin
                wait_cnt = 0;
                serve_request();
                mem_ready = 1'b1;
            end
        end
    end

endmodule

// File: verif/ddr_cache_tb.sv
`timescale 1ns/1ps

module ddr_cache_tb;
    import cache_pkg::*;

    localparam int set_bits      = 4;
    localparam int clk_period    = 40;
    localparam int drive_delay   = 2;
    localparam int reset_cycles  = 5;
    localparam int wait_limit    = 200;
    localparam int mem_line_bits = 10;
    localparam int shadow_words  = 4 * (2**mem_line_bits);
    localparam int max_entries   = 256;
    localparam int random_count  = 200;
    localparam int rand_seed     = 16778;

    // Memory traffic that one access is expected to cause
    localparam logic [1:0] traffic_any   = 2'd0;
    localparam logic [1:0] traffic_none  = 2'd1;
    localparam logic [1:0] traffic_fill  = 2'd2;
    localparam logic [1:0] traffic_flush = 2'd3;

    typedef struct packed {
        byte_addr_t addr;
        word_t      wdata;
        strb_t      strb;
        logic       exp_valid;
        word_t      exp_word;
        logic [1:0] traffic;
        mem_addr_t  wb_line;
    } access_t;

    logic       clk;
    logic       rst;
    byte_addr_t sys_addr;
    word_t      sys_wdata;
    word_t      sys_rdata;
    strb_t      sys_wstrb;
    logic       sys_valid;
    logic       sys_ready;
    mem_addr_t  mem_addr;
    line_data_t mem_wdata;
    line_data_t mem_rdata;
    logic       mem_write;
    logic       mem_valid;
    logic       mem_ready;

    access_t stim [max_entries];
    int      stim_count;
    word_t   shadow [shadow_words];

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    ddr_cache #(.set_bits(set_bits)) DUT (
        .clk, .rst, .sys_addr, .sys_wdata, .sys_rdata, .sys_wstrb, .sys_valid, .sys_ready,
        .mem_addr, .mem_wdata, .mem_rdata, .mem_write, .mem_valid, .mem_ready
    );

    ddr_mem_model #(.line_bits(mem_line_bits), .drive_delay(drive_delay)) u_mem (
        .clk, .rst, .mem_addr, .mem_wdata, .mem_write, .mem_valid, .mem_rdata, .mem_ready
    );

    ////////////////////////////////////////////////////////////////////
    // Reference rules and error handling
    ////////////////////////////////////////////////////////////////////

    function automatic word_t initial_word(byte_addr_t addr);
        return {9'd0, addr[24:2]} ^ 32'h5A5A0000;
    endfunction

    function automatic byte_addr_t make_addr(int tag, int set, int word);
        byte_addr_t addr;
        addr = '0;
        addr[24:set_bits+4] = tag;
        addr[set_bits+3:4]  = set;
        addr[3:2]           = word;
        return addr;
    endfunction

    // Bytes with a set strobe come from the new data
    function automatic word_t apply_strobes(word_t old, word_t wdata, strb_t strb);
        word_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old & ~mask) | (wdata & mask);
    endfunction

    task automatic stop_run();
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_problem(input string what);
        $display("ERROR at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string name, input mem_addr_t got, input mem_addr_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // A written-back line must equal the shadow copy of that line
    task automatic check_line(input mem_addr_t line, input line_data_t data);
        line_data_t exp;
        int         base;
        base = int'(line) * 4;
        for (int w = 0; w < 4; w++) begin
            exp[w*32 +: 32] = shadow[base + w];
        end
        if (data !== exp) begin
            $display("FAIL at %0t ns: mem_wdata of line %h = %h, expected %h",
                     $time, line, data, exp);
            stop_run();
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus table
    ////////////////////////////////////////////////////////////////////

    task automatic add_entry(input byte_addr_t addr, input word_t wdata, input strb_t strb,
                             input logic exp_valid, input word_t exp_word,
                             input logic [1:0] traffic, input mem_addr_t wb_line);
        stim[stim_count].addr      = addr;
        stim[stim_count].wdata     = wdata;
        stim[stim_count].strb      = strb;
        stim[stim_count].exp_valid = exp_valid;
        stim[stim_count].exp_word  = exp_word;
        stim[stim_count].traffic   = traffic;
        stim[stim_count].wb_line   = wb_line;
        stim_count++;
    endtask

    task automatic build_directed();
        byte_addr_t a_first;
        byte_addr_t a_part;
        byte_addr_t a_a;
        byte_addr_t a_b;
        byte_addr_t a_c;
        a_first = make_addr(1, 2, 0);
        a_part  = make_addr(1, 3, 1);
        a_a     = make_addr(2, 5, 0);
        a_b     = make_addr(3, 5, 1);
        a_c     = make_addr(4, 5, 2);
        // Untouched word straight after the sweep
        add_entry(a_first, '0, 4'h0, 1'b1, initial_word(a_first), traffic_fill, '0);
        // Partial write, then the merged word and its untouched neighbours
        add_entry(a_part, 32'hAABBCCDD, 4'b0101, 1'b0, '0, traffic_fill, '0);
        add_entry(a_part, '0, 4'h0, 1'b1,
                  (initial_word(a_part) & 32'hFF00FF00) | 32'h00BB00DD, traffic_none, '0);
        add_entry(make_addr(1, 3, 0), '0, 4'h0, 1'b1,
                  initial_word(make_addr(1, 3, 0)), traffic_none, '0);
        add_entry(make_addr(1, 3, 3), '0, 4'h0, 1'b1,
                  initial_word(make_addr(1, 3, 3)), traffic_none, '0);
        // Three tags in set 5; touching A again leaves B as the oldest
        add_entry(a_a, 32'h11111111, 4'hF, 1'b0, '0, traffic_fill, '0);
        add_entry(a_b, 32'h22222222, 4'hF, 1'b0, '0, traffic_fill, '0);
        add_entry(a_a, '0, 4'h0, 1'b1, 32'h11111111, traffic_none, '0);
        add_entry(a_c, 32'h33333333, 4'b0011, 1'b0, '0, traffic_flush, a_b[24:4]);
        // B comes back from memory and pushes out dirty A
        add_entry(a_b, '0, 4'h0, 1'b1, 32'h22222222, traffic_flush, a_a[24:4]);
        add_entry(a_c, '0, 4'h0, 1'b1,
                  (initial_word(a_c) & 32'hFFFF0000) | 32'h00003333, traffic_none, '0);
        // Clean B is the oldest now, so no write-back
        add_entry(a_a, '0, 4'h0, 1'b1, 32'h11111111, traffic_fill, '0);
    endtask

    task automatic add_random_traffic(input int count);
        int    tag;
        int    set;
        int    word;
        strb_t strb;
        for (int n = 0; n < count; n++) begin
            tag  = 8 + ($urandom % 3);
            set  = $urandom % 4;
            word = $urandom % 4;
            strb = ($urandom % 2 == 0) ? 4'h0 : strb_t'(1 + ($urandom % 15));
            add_entry(make_addr(tag, set, word), $urandom, strb, 1'b0, '0, traffic_any, '0);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Access sequencing
    ////////////////////////////////////////////////////////////////////

    // Entered and left a few ns after a rising edge
    task automatic run_access(input access_t acc, output word_t rdata, output int cycles);
        int fall_cycles;
        cycles      = 0;
        fall_cycles = 0;
        sys_addr    = acc.addr;
        sys_wdata   = acc.wdata;
        sys_wstrb   = acc.strb;
        sys_valid   = 1'b1;
        while (sys_ready !== 1'b1) begin
            @(posedge clk);
            #drive_delay;
            cycles++;
            if (cycles > wait_limit) begin
                report_problem("timed out waiting for sys_ready to rise");
            end
        end
        rdata     = sys_rdata;
        sys_valid = 1'b0;
        while (sys_ready !== 1'b0) begin
            @(posedge clk);
            #drive_delay;
            fall_cycles++;
            if (fall_cycles > wait_limit) begin
                report_problem("timed out waiting for sys_ready to fall");
            end
        end
    endtask

    task automatic apply_entry(input access_t acc, output int cycles);
        word_t rdata;
        int    fills_before;
        int    logs_before;
        int    new_fills;
        int    new_logs;
        int    sidx;
        fills_before = u_mem.fill_count;
        logs_before  = u_mem.log_count;
        run_access(acc, rdata, cycles);
        new_fills = u_mem.fill_count - fills_before;
        new_logs  = u_mem.log_count - logs_before;
        // The evicted line never is the accessed one, so the shadow still holds it
        for (int i = logs_before; i < u_mem.log_count; i++) begin
            check_line(u_mem.log_addr[i], u_mem.log_data[i]);
        end
        case (acc.traffic)
            traffic_none: begin
                if (new_fills != 0 || new_logs != 0) begin
                    report_problem("an expected cache hit reached the memory port");
                end
            end
            traffic_fill: begin
                if (new_fills != 1 || new_logs != 0) begin
                    report_problem("expected exactly one line fill and no write-back");
                end
            end
            traffic_flush: begin
                if (new_fills != 1 || new_logs != 1) begin
                    report_problem("expected one write-back followed by one line fill");
                end
                check_addr("mem_addr", u_mem.log_addr[logs_before], acc.wb_line);
            end
            default: begin
            end
        endcase
        sidx = int'(acc.addr[24:2]);
        if (acc.strb == '0) begin
            check_word("sys_rdata", rdata, acc.exp_valid ? acc.exp_word : shadow[sidx]);
        end else begin
            shadow[sidx] = apply_strobes(shadow[sidx], acc.wdata, acc.strb);
        end
    endtask

    initial begin
        int seed_draw;
        int cycles;
        rst       = 1'b1;
        sys_addr  = '0;
        sys_wdata = '0;
        sys_wstrb = '0;
        sys_valid = 1'b0;
        seed_draw = $urandom(rand_seed);
        stim_count = 0;
        for (int i = 0; i < shadow_words; i++) begin
            shadow[i] = word_t'(i) ^ 32'h5A5A0000;
        end
        build_directed();
        add_random_traffic(random_count);

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;

        // Nothing moves on either port before the first request
        repeat (3) begin
            @(posedge clk);
            #drive_delay;
            check_bit("sys_ready", sys_ready, 1'b0);
            check_bit("mem_valid", mem_valid, 1'b0);
        end

        for (int n = 0; n < stim_count; n++) begin
            apply_entry(stim[n], cycles);
            if (n == 0 && 3 + cycles < 2**set_bits) begin
                report_problem("first request finished before the invalidation sweep");
            end
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: project.f
logic/cache_pkg.sv
logic/cache_way_ram.sv
logic/hit_check.sv
logic/line_merge.sv
logic/init_sweep_counter.sv
logic/cache_ctrl.sv
logic/ddr_cache.sv
verif/ddr_mem_model.sv
verif/ddr_cache_tb.sv

// File: Bender.yml
package:
  name: ddr_cache

sources:
  - logic/cache_pkg.sv
  - logic/cache_way_ram.sv
  - logic/hit_check.sv
  - logic/line_merge.sv
  - logic/init_sweep_counter.sv
  - logic/cache_ctrl.sv
  - logic/ddr_cache.sv
  - target: test
    files:
      - verif/ddr_mem_model.sv
      - verif/ddr_cache_tb.sv
